// ==== ex_settings.svh ====
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Width of a full data word in bits.
`define EX_WORD_W 16

// Width of one slice handled per clock by the serial datapath.
// The word width must be an exact multiple of this.
`define EX_SLICE_W 4

// Number of architectural registers, with register 0 reading as zero.
`define EX_NUM_REGS 8

// Width of the conditional-execution state.
// Bit 0 holds the wanted value of P for the current instruction and the
// upper bits mark how many more instructions the run covers.
`define EX_COND_W 4

`endif

// ==== ex_pkg.sv ====
`default_nettype none

`include "ex_settings.svh"

package ex_pkg;

  // A full data word and the slice that the datapath works on each clock.
  typedef logic [`EX_WORD_W-1:0]  word_t;
  typedef logic [`EX_SLICE_W-1:0] slice_t;

  // Slice index, where zero selects the least significant slice.
  typedef logic [$clog2(`EX_WORD_W / `EX_SLICE_W)-1:0] ctr_t;

  // Register index. Register 0 is the zero register.
  typedef logic [$clog2(`EX_NUM_REGS)-1:0] reg_t;
  localparam reg_t REG_ZR = reg_t'(0);

  // Opcodes. The values above OP_COND are unused and do nothing.
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MOVI,
    OP_CMP,
    OP_COND
  } op_t;

  // Compare conditions used by OP_CMP to set the predicate.
  typedef enum logic [2:0] {
    CMP_EQ,
    CMP_NE,
    CMP_LT,
    CMP_LTU,
    CMP_GE,
    CMP_GEU
  } cmp_op_t;

  // Conditional-execution state.
  typedef logic [`EX_COND_W-1:0] cond_t;

  // The immediate fills every bit left over after the opcode and destination.
  localparam int unsigned IMM_W = `EX_WORD_W - $bits(op_t) - $bits(reg_t);

  // Register form, used by the ALU ops and by compares.
  typedef struct packed {
    op_t     op;
    reg_t    dst;
    reg_t    lhs;
    reg_t    rhs;
    cmp_op_t cmp;
  } reg_fmt_t;

  // Immediate form, used by MOVI and COND.
  typedef struct packed {
    op_t              op;
    reg_t             dst;
    logic [IMM_W-1:0] imm;
  } imm_fmt_t;

  // One instruction word seen through either format.
  // The opcode sits in the top bits of both views.
  typedef union packed {
    reg_fmt_t r;
    imm_fmt_t i;
  } enc_t;

endpackage

`default_nettype wire

// ==== ex_ctrl_if.sv ====
`default_nettype none

// Decoded control for the instruction currently held by the decoder.
interface ex_ctrl_if import ex_pkg::*; ();

  op_t     op;
  reg_t    dst;
  reg_t    lhs;
  reg_t    rhs;
  cmp_op_t cmp;
  word_t   imm;
  cond_t   cond_val;
  logic    wr_reg;

  // The decoder is the only driver.
  modport decoder (
    output op, dst, lhs, rhs, cmp, imm, cond_val, wr_reg
  );

  // The register file needs the operand and destination indices.
  modport regfile (
    input dst, lhs, rhs, wr_reg
  );

  // The ALU picks its function from the opcode and takes MOVI data from imm.
  modport alu (
    input op, imm
  );

  // The predicate logic handles CMP and COND.
  modport pred (
    input op, cmp, cond_val
  );

endinterface

`default_nettype wire

// ==== ex_decode.sv ====
`default_nettype none

`include "ex_settings.svh"

// Holds the accepted instruction and turns it into datapath control.
module ex_decode import ex_pkg::*; (
  input  var logic      i_ex_gck,
  input  var logic      i_ex_rst_n,

  input  var enc_t      i_enc,
  input  var logic      i_start,

  ex_ctrl_if.decoder    ctrl
);

  // Instruction word captured at acceptance.
  enc_t enc_q;

  // Set when the word is read through the immediate view.
  logic imm_form;

  // The requester holds the word stable while req is high, so the word is
  // captured on the start pulse and kept for the four execute cycles.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      enc_q <= '0;
    end
    else if (i_start) begin
      enc_q <= i_enc;
    end
  end

  // Both views place the opcode in the same bits, so either can be used.
  always_comb ctrl.op = enc_q.r.op;

  // MOVI and COND carry an immediate, everything else uses register operands.
  always_comb imm_form = ctrl.op == OP_MOVI || ctrl.op == OP_COND;

  // Pick the fields from the view that matches the opcode.
  // The immediate form reads zero for both sources.
  always_comb begin
    if (imm_form) begin
      ctrl.dst = enc_q.i.dst;
      ctrl.lhs = REG_ZR;
      ctrl.rhs = REG_ZR;
      ctrl.cmp = CMP_EQ;
      ctrl.imm = word_t'(enc_q.i.imm);
    end
    else begin
      ctrl.dst = enc_q.r.dst;
      ctrl.lhs = enc_q.r.lhs;
      ctrl.rhs = enc_q.r.rhs;
      ctrl.cmp = enc_q.r.cmp;
      ctrl.imm = '0;
    end
  end

  // COND takes its new state from the low immediate bits.
  always_comb ctrl.cond_val = ctrl.op == OP_COND ? enc_q.i.imm[`EX_COND_W-1:0]
                                                 : '0;

  // Only the ALU ops and MOVI produce a register result.
  // Writes to the zero register are dropped here.
  always_comb ctrl.wr_reg = ctrl.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MOVI}
                         && ctrl.dst != REG_ZR;

endmodule

`default_nettype wire

// ==== ex_seq.sv ====
`default_nettype none

// Four-phase req/ack handshake and the slice counter for execution.
module ex_seq import ex_pkg::*; (
  input  var logic i_ex_gck,
  input  var logic i_ex_rst_n,

  input  var logic i_req,
  output var logic o_ack,

  output var logic o_start,
  output var logic o_run,
  output var logic o_last,
  output var ctr_t o_ctr
);

  // Idle waits for a request, execute walks the slices and acknowledge
  // holds ack until the requester lets go of req.
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_ACK
  } state_t;

  state_t state_q;
  logic   start_q;
  ctr_t   ctr_q;

  // A request is accepted only from idle, where ack is already low.
  // The start pulse then lasts one cycle, during which the decoder captures
  // the word, and the four execute cycles follow.
  // Ack therefore rises five edges after the accepting one.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      state_q <= ST_IDLE;
      start_q <= 1'b0;
      ctr_q   <= '0;
    end
    else begin
      start_q <= 1'b0;

      unique case (state_q)
        ST_IDLE: begin
          if (start_q) begin
            state_q <= ST_EXEC;
          end
          else if (i_req) begin
            start_q <= 1'b1;
          end
        end
        ST_EXEC: begin
          // The counter wraps back to zero after the top slice.
          ctr_q <= ctr_q + ctr_t'(1);
          if (&ctr_q) begin
            state_q <= ST_ACK;
          end
        end
        default: begin
          // Back-pressure is just req held high, so wait here.
          if (!i_req) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_comb o_ack   = state_q == ST_ACK;
  always_comb o_start = start_q;
  always_comb o_run   = state_q == ST_EXEC;
  always_comb o_ctr   = ctr_q;

  // Last slice of the instruction.
  always_comb o_last  = o_run && &ctr_q;

endmodule

`default_nettype wire

// ==== ex_regfile.sv ====
`default_nettype none

`include "ex_settings.svh"

// Register file read and written one slice at a time.
module ex_regfile import ex_pkg::*; (
  input  var logic   i_ex_gck,
  input  var logic   i_ex_rst_n,

  ex_ctrl_if.regfile ctrl,

  input  var ctr_t   i_ctr,
  input  var logic   i_run,
  input  var logic   i_skip,

  input  var slice_t i_wr_slice,
  output var slice_t o_lhs_slice,
  output var slice_t o_rhs_slice,

  input  var reg_t   i_dbg_sel,
  output var word_t  o_dbg_data
);

  // Storage exists only for the writable registers.
  word_t regs_q [1:`EX_NUM_REGS-1];

  // Read view of every register, with register 0 tied to zero.
  word_t rd_view [`EX_NUM_REGS];

  // Write enable for the current slice.
  logic wr_en;

  always_comb begin
    rd_view[0] = '0;
    for (int i = 1; i < `EX_NUM_REGS; i++) begin
      rd_view[i] = regs_q[i];
    end
  end

  // Both operands read the slice selected by the counter.
  always_comb o_lhs_slice = rd_view[ctrl.lhs][i_ctr*`EX_SLICE_W +: `EX_SLICE_W];
  always_comb o_rhs_slice = rd_view[ctrl.rhs][i_ctr*`EX_SLICE_W +: `EX_SLICE_W];

  // Whole-word view for the debug port.
  always_comb o_dbg_data = rd_view[i_dbg_sel];

  // A skipped instruction leaves its destination alone.
  always_comb wr_en = i_run && !i_skip && ctrl.wr_reg;

  // Each execute cycle writes one slice of the destination.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      for (int i = 1; i < `EX_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end
    else if (wr_en) begin
      for (int i = 1; i < `EX_NUM_REGS; i++) begin
        if (ctrl.dst == reg_t'(i)) begin
          regs_q[i][i_ctr*`EX_SLICE_W +: `EX_SLICE_W] <= i_wr_slice;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== ex_alu.sv ====
`default_nettype none

`include "ex_settings.svh"

// Slice-serial ALU. The carry and zero state ride from one slice to the next.
module ex_alu import ex_pkg::*; (
  input  var logic   i_ex_gck,

  ex_ctrl_if.alu     ctrl,

  input  var ctr_t   i_ctr,
  input  var logic   i_run,

  input  var slice_t i_lhs,
  input  var slice_t i_rhs,
  output var slice_t o_out,

  output var logic   o_flag_z,
  output var logic   o_flag_n,
  output var logic   o_flag_c,
  output var logic   o_flag_v
);

  // Subtract and compare add the inverted rhs.
  logic inv;
  logic cin;

  slice_t               rhs_eff;
  logic [`EX_SLICE_W:0] sum;

  // Carry out and running zero state from the previous slice.
  logic carry_q;
  logic zero_q;
  logic zero_now;

  always_comb inv = ctrl.op == OP_SUB || ctrl.op == OP_CMP;

  // Slice 0 takes the carry in from the op, later slices take the saved carry.
  always_comb cin = i_ctr == '0 ? inv : carry_q;

  always_comb rhs_eff = inv ? ~i_rhs : i_rhs;

  always_comb sum = {1'b0, i_lhs} + {1'b0, rhs_eff} + {{`EX_SLICE_W{1'b0}}, cin};

  // Result slice for the current op. COND and the unused opcodes give zero.
  always_comb begin
    case (ctrl.op)
      OP_ADD, OP_SUB, OP_CMP: o_out = sum[`EX_SLICE_W-1:0];
      OP_AND:                 o_out = i_lhs & i_rhs;
      OP_OR:                  o_out = i_lhs | i_rhs;
      OP_XOR:                 o_out = i_lhs ^ i_rhs;
      OP_MOVI:                o_out = ctrl.imm[i_ctr*`EX_SLICE_W +: `EX_SLICE_W];
      default:                o_out = '0;
    endcase
  end

  // The whole word is zero only if every slice so far was zero.
  always_comb zero_now = (o_out == '0) && (i_ctr == '0 || zero_q);

  // Carry and zero state advance on every execute cycle.
  always_ff @(posedge i_ex_gck) begin
    if (i_run) begin
      carry_q <= sum[`EX_SLICE_W];
      zero_q  <= zero_now;
    end
  end

  // Flags are read on the last slice, where they describe the whole word.
  always_comb o_flag_z = zero_now;
  always_comb o_flag_n = o_out[`EX_SLICE_W-1];
  always_comb o_flag_c = sum[`EX_SLICE_W];

  // Signed overflow when both inputs agree in sign and the result does not.
  always_comb o_flag_v = (i_lhs[`EX_SLICE_W-1] == rhs_eff[`EX_SLICE_W-1])
                      && (sum[`EX_SLICE_W-1] != i_lhs[`EX_SLICE_W-1]);

endmodule

`default_nettype wire

// ==== ex_pred.sv ====
`default_nettype none

`include "ex_settings.svh"

// Predicate register and the conditional-execution state.
module ex_pred import ex_pkg::*; (
  input  var logic i_ex_gck,
  input  var logic i_ex_rst_n,

  ex_ctrl_if.pred  ctrl,

  input  var logic i_last,
  input  var logic i_run,

  input  var logic i_flag_z,
  input  var logic i_flag_n,
  input  var logic i_flag_c,
  input  var logic i_flag_v,

  output var logic o_skip,
  output var logic o_pred
);

  logic  pred_q;
  cond_t cond_q;

  // Set while a run of conditional instructions is in progress.
  logic cond_active;

  // Instruction finishing this cycle and actually executing.
  logic done;
  logic cmp_res;

  // The state only counts while some bit above bit 0 is set. Bit 0 then
  // holds the value that P must have for the instruction to run.
  always_comb cond_active = |cond_q[`EX_COND_W-1:1];

  // Nothing is skipped outside execution.
  always_comb o_skip = i_run && cond_active && (pred_q != cond_q[0]);

  always_comb done = i_last && !o_skip;

  // Map the compare condition onto the flags of the subtraction.
  always_comb begin
    case (ctrl.cmp)
      CMP_EQ:  cmp_res = i_flag_z;
      CMP_NE:  cmp_res = !i_flag_z;
      CMP_LT:  cmp_res = i_flag_n != i_flag_v;
      CMP_LTU: cmp_res = !i_flag_c;
      CMP_GE:  cmp_res = i_flag_n == i_flag_v;
      CMP_GEU: cmp_res = i_flag_c;
      // Codes 6 and 7 are unused and clear P.
      default: cmp_res = 1'b0;
    endcase
  end

  // P is written at the end of an executed compare.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= 1'b0;
    end
    else if (done && ctrl.op == OP_CMP) begin
      pred_q <= cmp_res;
    end
  end

  // An executed COND loads a new state. Every other instruction, skipped
  // or not, moves the state on by one position.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      cond_q <= '0;
    end
    else if (i_last) begin
      if (done && ctrl.op == OP_COND) begin
        cond_q <= ctrl.cond_val;
      end
      else begin
        cond_q <= {1'b0, cond_q[`EX_COND_W-1:1]};
      end
    end
  end

  always_comb o_pred = pred_q;

endmodule

`default_nettype wire

// ==== ex_core.sv ====
`default_nettype none

// Execute stage of the bit-sliced core with a req/ack instruction port.
module ex_core import ex_pkg::*; (
  input  var logic  i_ex_gck,
  input  var logic  i_ex_rst_n,

  // Instruction handshake. The word is held stable while req is high.
  input  var logic  i_ex_req,
  input  var enc_t  i_ex_enc,
  output var logic  o_ex_ack,

  // Predicate and register read for the testbench.
  output var logic  o_ex_pred,
  input  var reg_t  i_ex_dbg_sel,
  output var word_t o_ex_dbg_data
);

  // Sequencing from the handshake block.
  logic start;
  logic run;
  logic last;
  ctr_t ctr;

  // Conditional skip of the running instruction.
  logic skip;

  // Operand and result slices.
  slice_t lhs_slice;
  slice_t rhs_slice;
  slice_t alu_out;

  // ALU flags, valid on the last slice.
  logic flag_z;
  logic flag_n;
  logic flag_c;
  logic flag_v;

  // Decoded control shared by the datapath.
  ex_ctrl_if ctrl_if ();

  ex_seq seq_u (
    .i_ex_gck   (i_ex_gck),
    .i_ex_rst_n (i_ex_rst_n),
    .i_req      (i_ex_req),
    .o_ack      (o_ex_ack),
    .o_start    (start),
    .o_run      (run),
    .o_last     (last),
    .o_ctr      (ctr)
  );

  ex_decode decode_u (
    .i_ex_gck   (i_ex_gck),
    .i_ex_rst_n (i_ex_rst_n),
    .i_enc      (i_ex_enc),
    .i_start    (start),
    .ctrl       (ctrl_if.decoder)
  );

  ex_regfile regfile_u (
    .i_ex_gck    (i_ex_gck),
    .i_ex_rst_n  (i_ex_rst_n),
    .ctrl        (ctrl_if.regfile),
    .i_ctr       (ctr),
    .i_run       (run),
    .i_skip      (skip),
    .i_wr_slice  (alu_out),
    .o_lhs_slice (lhs_slice),
    .o_rhs_slice (rhs_slice),
    .i_dbg_sel   (i_ex_dbg_sel),
    .o_dbg_data  (o_ex_dbg_data)
  );

  ex_alu alu_u (
    .i_ex_gck (i_ex_gck),
    .ctrl     (ctrl_if.alu),
    .i_ctr    (ctr),
    .i_run    (run),
    .i_lhs    (lhs_slice),
    .i_rhs    (rhs_slice),
    .o_out    (alu_out),
    .o_flag_z (flag_z),
    .o_flag_n (flag_n),
    .o_flag_c (flag_c),
    .o_flag_v (flag_v)
  );

  ex_pred pred_u (
    .i_ex_gck   (i_ex_gck),
    .i_ex_rst_n (i_ex_rst_n),
    .ctrl       (ctrl_if.pred),
    .i_last     (last),
    .i_run      (run),
    .i_flag_z   (flag_z),
    .i_flag_n   (flag_n),
    .i_flag_c   (flag_c),
    .i_flag_v   (flag_v),
    .o_skip     (skip),
    .o_pred     (o_ex_pred)
  );

endmodule

`default_nettype wire

// ==== tb_ex_core.sv ====
`default_nettype none

`include "ex_settings.svh"

// Directed testbench for the execute stage, checked against a word-level model.
module tb_ex_core import ex_pkg::*; ();

  localparam int CLK_HALF = 2;

  // Instruction counts per test, used to size the watchdog.
  localparam int N_ARITH_RAND = 24;
  localparam int N_ARITH = 12 + N_ARITH_RAND;
  localparam int N_LOGIC = 24;
  localparam int N_CMP_FIXED = 7;
  localparam int N_CMP_PAIRS = N_CMP_FIXED + 3;
  localparam int N_CMP = 11 + 6 * N_CMP_PAIRS;
  localparam int N_COND_VALS = 8;
  localparam int N_COND = N_COND_VALS * 2 * 6;
  localparam int N_HS = 8;
  localparam int N_INSTR = N_ARITH + N_LOGIC + N_CMP + N_COND + N_HS;

  // One instruction takes at most 16 cycles including the longest hold.
  localparam int WATCHDOG_CYCLES = N_INSTR * 20 + 200;
  localparam int ACK_WAIT_LIMIT = 20;

  logic  ex_gck;
  logic  ex_rst_n;
  logic  ex_req;
  enc_t  ex_enc;
  logic  ex_ack;
  logic  ex_pred;
  reg_t  ex_dbg_sel;
  word_t ex_dbg_data;

  integer seed = 32'he3da_390b;

  // Model of the architectural state.
  word_t model_regs [`EX_NUM_REGS];
  logic  model_pred;
  cond_t model_cond;

  ex_core dut (
    .i_ex_gck      (ex_gck),
    .i_ex_rst_n    (ex_rst_n),
    .i_ex_req      (ex_req),
    .i_ex_enc      (ex_enc),
    .o_ex_ack      (ex_ack),
    .o_ex_pred     (ex_pred),
    .i_ex_dbg_sel  (ex_dbg_sel),
    .o_ex_dbg_data (ex_dbg_data)
  );

  initial begin
    ex_gck = 1'b0;
    forever #CLK_HALF ex_gck = ~ex_gck;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("Error at time %0t: %s: got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [8:0] rand_imm();
    logic [31:0] r;
    r = $random(seed);
    return r[8:0];
  endfunction

  function automatic logic [2:0] rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return r[2:0];
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // Register form is op, dst, lhs, rhs, cmp from the top bit down.
  function automatic logic [15:0] reg_form(input logic [3:0] op, input logic [2:0] dst,
                                           input logic [2:0] lhs, input logic [2:0] rhs,
                                           input logic [2:0] cmp);
    return {op, dst, lhs, rhs, cmp};
  endfunction

  function automatic logic [15:0] imm_form(input logic [3:0] op, input logic [2:0] dst,
                                           input logic [8:0] imm);
    return {op, dst, imm};
  endfunction

  function automatic logic cmp_true(input logic [2:0] cmp, input word_t a, input word_t b);
    case (cmp)
      CMP_EQ:  return a == b;
      CMP_NE:  return a != b;
      CMP_LT:  return $signed(a) < $signed(b);
      CMP_LTU: return a < b;
      CMP_GE:  return $signed(a) >= $signed(b);
      CMP_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Applies one instruction to the model, honoring the skip rule.
  task automatic update_model(input logic [15:0] enc);
    logic [3:0] op;
    logic [2:0] dst;
    word_t      a;
    word_t      b;
    word_t      res;
    logic       skip;
    logic       wr;
    op = enc[15:12];
    dst = enc[11:9];
    a = model_regs[enc[8:6]];
    b = model_regs[enc[5:3]];
    skip = (|model_cond[3:1]) && (model_pred != model_cond[0]);
    wr = 1'b1;
    res = '0;
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_MOVI: res = word_t'(enc[8:0]);
      default: wr = 1'b0;
    endcase
    if (!skip && wr && dst != 3'd0) begin
      model_regs[dst] = res;
    end
    if (!skip && op == OP_CMP) begin
      model_pred = cmp_true(enc[2:0], a, b);
    end
    // The state moves on once per instruction unless a COND reloads it.
    if (!skip && op == OP_COND) begin
      model_cond = enc[3:0];
    end
    else begin
      model_cond = model_cond >> 1;
    end
  endtask

  // One full req/ack cycle, holding req for extra cycles after ack rises.
  task automatic exec(input logic [15:0] enc, input int hold);
    int          n;
    logic [2:0]  dst;
    logic [31:0] junk;
    dst = enc[11:9];
    n = 0;
    @(posedge ex_gck);
    ex_req <= 1'b1;
    ex_enc <= enc;
    ex_dbg_sel <= dst;
    do begin
      @(posedge ex_gck);
      n++;
      @(negedge ex_gck);
    end while (!ex_ack && n < ACK_WAIT_LIMIT);
    if (!ex_ack) begin
      abort_run("Timeout: the core never acknowledged an instruction");
    end
    // One edge samples req, then five more bring ack up.
    check_eq(n, 6, "edges from req to ack");
    update_model(enc);
    check_eq(32'(ex_dbg_data), 32'(model_regs[dst]), "destination register");
    check_eq(32'(ex_pred), 32'(model_pred), "predicate");
    repeat (hold) begin
      @(posedge ex_gck);
      @(negedge ex_gck);
      check_eq(32'(ex_ack), 1, "ack while req is held");
      check_eq(32'(ex_dbg_data), 32'(model_regs[dst]), "destination during back-pressure");
    end
    junk = $random(seed);
    @(posedge ex_gck);
    ex_req <= 1'b0;
    ex_enc <= junk[15:0];
    @(negedge ex_gck);
    check_eq(32'(ex_ack), 1, "ack before req low is sampled");
    @(posedge ex_gck);
    @(negedge ex_gck);
    check_eq(32'(ex_ack), 0, "ack after req low is sampled");
  endtask

  task automatic check_all_regs(input string what);
    for (int r = 0; r < `EX_NUM_REGS; r++) begin
      @(posedge ex_gck);
      ex_dbg_sel <= reg_t'(r);
      @(negedge ex_gck);
      check_eq(32'(ex_dbg_data), 32'(model_regs[r]), $sformatf("%s r%0d", what, r));
    end
  endtask

  task automatic test_reset();
    @(negedge ex_gck);
    check_eq(32'(ex_ack), 0, "ack after reset");
    check_eq(32'(ex_pred), 0, "predicate after reset");
    check_all_regs("register after reset");
  endtask

  task automatic test_arith();
    for (int r = 1; r < `EX_NUM_REGS; r++) begin
      exec(imm_form(OP_MOVI, reg_t'(r), rand_imm()), rand_below(3));
    end
    // Register 0 ignores writes.
    exec(imm_form(OP_MOVI, 3'd0, 9'h1ab), 0);
    exec(reg_form(OP_ADD, 3'd0, 3'd1, 3'd2, 3'd0), 0);
    // A borrow and a carry through all four slices.
    exec(imm_form(OP_MOVI, 3'd1, 9'h1ff), 0);
    exec(reg_form(OP_SUB, 3'd2, 3'd0, 3'd1, 3'd0), 1);
    exec(reg_form(OP_ADD, 3'd3, 3'd2, 3'd1, 3'd0), 2);
    repeat (N_ARITH_RAND) begin
      exec(reg_form(rand_below(2) == 0 ? OP_ADD : OP_SUB, rand_reg(), rand_reg(),
                    rand_reg(), rand_reg()), rand_below(3));
    end
    check_all_regs("register after arithmetic");
  endtask

  task automatic test_logic();
    logic [3:0] op;
    repeat (N_LOGIC) begin
      case (rand_below(3))
        0:       op = OP_AND;
        1:       op = OP_OR;
        default: op = OP_XOR;
      endcase
      exec(reg_form(op, rand_reg(), rand_reg(), rand_reg(), rand_reg()), rand_below(3));
    end
    check_all_regs("register after logic ops");
  endtask

  task automatic test_cmp();
    logic [2:0] pair_lhs [N_CMP_FIXED] = '{3'd1, 3'd2, 3'd1, 3'd3, 3'd4, 3'd0, 3'd2};
    logic [2:0] pair_rhs [N_CMP_FIXED] = '{3'd1, 3'd1, 3'd2, 3'd4, 3'd3, 3'd2, 3'd0};
    // Edge operands with r1 at 1, r2 all ones, r3 the signed minimum and r4 the maximum.
    exec(imm_form(OP_MOVI, 3'd1, 9'd1), 0);
    exec(reg_form(OP_SUB, 3'd2, 3'd0, 3'd1, 3'd0), 0);
    exec(imm_form(OP_MOVI, 3'd3, 9'h100), 0);
    repeat (7) begin
      exec(reg_form(OP_ADD, 3'd3, 3'd3, 3'd3, 3'd0), 0);
    end
    exec(reg_form(OP_SUB, 3'd4, 3'd3, 3'd1, 3'd0), 0);
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < N_CMP_PAIRS; p++) begin
        if (p < N_CMP_FIXED) begin
          exec(reg_form(OP_CMP, rand_reg(), pair_lhs[p], pair_rhs[p], 3'(c)), rand_below(3));
        end
        else begin
          exec(reg_form(OP_CMP, rand_reg(), rand_reg(), rand_reg(), 3'(c)), rand_below(3));
        end
      end
    end
    check_all_regs("register after compares");
  endtask

  // A random instruction that may change a register or P inside a COND run.
  task automatic exec_follower();
    logic [3:0] op;
    logic [2:0] dst;
    op = 4'(rand_below(7));
    dst = 3'(rand_below(`EX_NUM_REGS - 1) + 1);
    if (op == OP_MOVI) begin
      exec(imm_form(op, dst, rand_imm()), rand_below(3));
    end
    else begin
      exec(reg_form(op, dst, rand_reg(), rand_reg(), 3'(rand_below(6))), rand_below(3));
    end
  endtask

  task automatic test_cond();
    cond_t      fixed_vals [5] = '{4'b1111, 4'b1010, 4'b0101, 4'b0110, 4'b1001};
    logic [8:0] imm;
    for (int v = 0; v < N_COND_VALS; v++) begin
      for (int p = 0; p < 2; p++) begin
        // Comparing r0 with itself sets P to a known value.
        exec(reg_form(OP_CMP, 3'd0, 3'd0, 3'd0, p == 1 ? CMP_EQ : CMP_NE), 0);
        imm = rand_imm();
        if (v < 5) begin
          imm[3:0] = fixed_vals[v];
        end
        exec(imm_form(OP_COND, rand_reg(), imm), rand_below(3));
        repeat (4) begin
          exec_follower();
        end
      end
    end
    check_all_regs("register after conditional runs");
  endtask

  task automatic test_handshake();
    repeat (N_HS) begin
      exec(imm_form(OP_MOVI, 3'(rand_below(`EX_NUM_REGS - 1) + 1), rand_imm()),
           3 + rand_below(5));
    end
    check_all_regs("register after back-pressure");
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ex_gck);
    abort_run($sformatf("Timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin
    ex_rst_n = 1'b0;
    ex_req = 1'b0;
    ex_enc = '0;
    ex_dbg_sel = '0;
    model_pred = 1'b0;
    model_cond = '0;
    for (int r = 0; r < `EX_NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    repeat (4) @(posedge ex_gck);
    ex_rst_n <= 1'b1;
    test_reset();
    test_arith();
    test_logic();
    test_cmp();
    test_cond();
    test_handshake();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
ex_pkg.sv
ex_ctrl_if.sv
ex_decode.sv
ex_seq.sv
ex_regfile.sv
ex_alu.sv
ex_pred.sv
ex_core.sv
tb_ex_core.sv

// ==== Makefile ====
# Verilator flow for the execute stage testbench.

VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= tb_ex_core
RTL_TOP   ?= ex_core
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
